/* all.f */
source/fp64_pkg.sv
source/fpu_op_pkg.sv
source/fpu_item_if.sv
source/fpu_operand_unit.sv
source/fpu_result_queue.sv
source/fpu_round_pack.sv
source/fpu_top.sv
testbench/fpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the FPU testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fpu_tb \
   --Mdir obj_dir -o fpu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
   exit 0
fi
exit 1

/* testbench/fpu_tb.sv */
// Self-checking testbench for the FPU multiply and sign-injection unit, compiled from all.f with top fpu_tb
module fpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import fp64_pkg::*;
   import fpu_op_pkg::*;

   localparam int N_RANDOM = 24;
   localparam int NUM_OPS  = 2 * N_RANDOM + 22;

   logic        clk;
   logic        rst;
   logic        enable;
   logic [4:0]  fpu_op;
   logic [2:0]  rnd_mode;
   logic [63:0] opa;
   logic [63:0] opb;
   logic [63:0] out;
   logic        ready;
   logic        overflow;
   logic        underflow;
   logic        inexact;
   logic        invalid;

   // Expected response of the operation in flight, flags as {overflow, underflow, inexact, invalid}
   logic [63:0] exp_out;
   logic [3:0]  exp_flags;
   string       test_name;
   logic        started;

   int seed;
   int value_errors;
   int protocol_errors;
   int op_count;

   fpu_top #(.MUL_BITS(4), .QUEUE_DEPTH(2)) uut
   (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .fpu_op    (fpu_op),
      .rnd_mode  (rnd_mode),
      .opa       (opa),
      .opb       (opb),
      .out       (out),
      .ready     (ready),
      .overflow  (overflow),
      .underflow (underflow),
      .inexact   (inexact),
      .invalid   (invalid)
   );

   always #4 clk = ~clk;

   //////////////////////////////
   // Result and protocol checks
   //////////////////////////////

   // Outputs are compared one edge after ready rises, while they still hold
   assert property (@(posedge clk) disable iff (rst) $rose(ready) |-> (out == exp_out))
   else
   begin
      value_errors = value_errors + 1;
      $display("Error: %s out expected %h actual %h", test_name, exp_out, out);
   end

   assert property (@(posedge clk) disable iff (rst)
      $rose(ready) |-> ({overflow, underflow, inexact, invalid} == exp_flags))
   else
   begin
      value_errors = value_errors + 1;
      $display("Error: %s flags expected %b actual %b", test_name, exp_flags,
               {overflow, underflow, inexact, invalid});
   end

   assert property (@(posedge clk) $fell(rst) |-> !ready)
   else
   begin
      protocol_errors = protocol_errors + 1;
      $display("Protocol: ready was high right after reset");
   end

   assert property (@(posedge clk) disable iff (rst) $rose(ready) |-> started)
   else
   begin
      protocol_errors = protocol_errors + 1;
      $display("Protocol: ready rose although no operation was started");
   end

   assert property (@(posedge clk) disable iff (rst) (ready && enable) |=> ready)
   else
   begin
      protocol_errors = protocol_errors + 1;
      $display("Protocol: ready dropped in %s while enable was still high", test_name);
   end

   assert property (@(posedge clk) disable iff (rst) !enable |=> !ready)
   else
   begin
      protocol_errors = protocol_errors + 1;
      $display("Protocol: ready stayed high after enable was sampled low in %s", test_name);
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   task automatic model_mul(input logic [63:0] a, input logic [63:0] b, input logic [2:0] rm,
                            output logic [63:0] res, output logic [3:0] flags);
      logic [105:0] prod;
      logic [52:0]  sig;
      logic         sgn;
      logic         g;
      logic         s;
      int           e;
      sgn   = a[63] ^ b[63];
      flags = 4'b0000;
      if ((a[62:52] == 11'h7FF && a[51:0] != 0) || (b[62:52] == 11'h7FF && b[51:0] != 0)
          || (a[62:52] == 11'h7FF && b[62:52] == 0) || (a[62:52] == 0 && b[62:52] == 11'h7FF))
      begin
         res   = QNAN;
         flags = 4'b0001;
      end
      else if (a[62:52] == 11'h7FF || b[62:52] == 11'h7FF)
         res = {sgn, 11'h7FF, 52'd0};
      else if (a[62:52] == 0 || b[62:52] == 0)
         res = {sgn, 63'd0};
      else
      begin
         prod = 106'({1'b1, a[51:0]}) * 106'({1'b1, b[51:0]});
         e    = int'(a[62:52]) + int'(b[62:52]) - 1023;
         if (prod[105])
            e = e + 1;
         else
            prod = prod << 1;
         sig = prod[105:53];
         g   = prod[52];
         s   = |prod[51:0];
         if (rm != RM_RTZ && g && (s || sig[0]))
         begin
            // All ones plus one becomes 1.0 at the next exponent
            if (sig == '1)
            begin
               sig = 53'h10_0000_0000_0000;
               e   = e + 1;
            end
            else
               sig = sig + 1'b1;
         end
         if (e >= 2047)
         begin
            flags = 4'b1010;
            res   = (rm == RM_RTZ) ? {sgn, MAX_FINITE_MAG[62:0]} : {sgn, 11'h7FF, 52'd0};
         end
         else if (e < 1)
         begin
            flags = 4'b0110;
            res   = {sgn, 63'd0};
         end
         else
         begin
            flags = {2'b00, g | s, 1'b0};
            res   = {sgn, e[10:0], sig[51:0]};
         end
      end
   endtask

   // Normal operand whose exponent keeps any product of two of them in range
   task automatic make_normal(output logic [63:0] w);
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      logic [31:0] r_e;
      r_hi = $random(seed);
      r_lo = $random(seed);
      r_e  = $random(seed);
      w    = {r_hi[31], 11'(823 + (r_e % 400)), r_hi[19:0], r_lo};
   endtask

   // Called on a falling edge, returns on the falling edge where ready is low again
   task automatic run_op(input string name, input logic [4:0] op, input logic [2:0] rm,
                         input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] want_out, input logic [3:0] want_flags);
      test_name = name;
      exp_out   = want_out;
      exp_flags = want_flags;
      fpu_op    = op;
      rnd_mode  = rm;
      opa       = a;
      opb       = b;
      started   = 1'b1;
      enable    = 1'b1;
      do
         @(negedge clk);
      while (!ready);
      // Some operations keep enable high a little longer
      repeat (op_count % 3)
         @(negedge clk);
      enable = 1'b0;
      do
         @(negedge clk);
      while (ready);
      started  = 1'b0;
      op_count = op_count + 1;
   endtask

   task automatic check_mul(input string name, input logic [2:0] rm,
                            input logic [63:0] a, input logic [63:0] b);
      logic [63:0] want;
      logic [3:0]  flags;
      model_mul(a, b, rm, want, flags);
      run_op(name, OP_MUL, rm, a, b, want, flags);
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial
   begin : stimulus
      logic [63:0] a;
      logic [63:0] b;
      clk             = 1'b0;
      rst             = 1'b1;
      enable          = 1'b0;
      fpu_op          = '0;
      rnd_mode        = '0;
      opa             = '0;
      opb             = '0;
      exp_out         = '0;
      exp_flags       = '0;
      test_name       = "reset";
      started         = 1'b0;
      seed            = 55;
      value_errors    = 0;
      protocol_errors = 0;
      op_count        = 0;
      repeat (3)
         @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < N_RANDOM; i++)
      begin
         make_normal(a);
         make_normal(b);
         check_mul($sformatf("mul_rne_%0d", i), RM_RNE, a, b);
         check_mul($sformatf("mul_rtz_%0d", i), RM_RTZ, a, b);
      end
      make_normal(a);
      make_normal(b);
      check_mul("mul_code4", 3'd4, a, b);
      check_mul("mul_code7", 3'd7, a, b);
      check_mul("mul_exact", RM_RNE, 64'h3FF8_0000_0000_0000, 64'h4000_0000_0000_0000);

      // Special operands, a subnormal counts as zero
      check_mul("zero_times_finite", RM_RNE, 64'h0, 64'hC008_0000_0000_0000);
      check_mul("finite_times_negzero", RM_RNE, 64'h3FF8_0000_0000_0000, 64'h8000_0000_0000_0000);
      check_mul("subnormal_times_finite", RM_RTZ, 64'h1, 64'h4000_0000_0000_0000);
      check_mul("inf_times_finite", RM_RNE, 64'h7FF0_0000_0000_0000, 64'hC000_0000_0000_0000);
      check_mul("inf_times_zero", RM_RNE, 64'h7FF0_0000_0000_0000, 64'h0);
      check_mul("nan_times_finite", RM_RNE, 64'h7FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000);
      check_mul("finite_times_nan", RM_RTZ, 64'h3FF8_0000_0000_0000, 64'hFFF8_0000_0000_0000);

      // Range limits
      check_mul("overflow_rne", RM_RNE, 64'h7FE0_0000_0000_0000, 64'h7FE0_0000_0000_0000);
      check_mul("overflow_rtz", RM_RTZ, 64'h7FE0_0000_0000_0000, 64'h7FE0_0000_0000_0000);
      check_mul("overflow_rtz_neg", RM_RTZ, 64'hFFE0_0000_0000_0000, 64'h7FE0_0000_0000_0000);
      check_mul("underflow_pos", RM_RNE, 64'h0010_0000_0000_0001, 64'h0010_0000_0000_0001);
      check_mul("underflow_neg", RM_RTZ, 64'h8010_0000_0000_0001, 64'h0010_0000_0000_0001);

      // Sign injection and unsupported operations
      a = 64'h4009_21FB_5444_2D18;
      b = 64'hBFF0_0000_0000_0000;
      run_op("sgnj_copy0", OP_SGNJ, 3'd0, a, b, {b[63], a[62:0]}, 4'b0000);
      run_op("sgnj_copy1", OP_SGNJ, 3'd1, b, a, {a[63], b[62:0]}, 4'b0000);
      run_op("sgnj_pass", OP_SGNJ, SGNJ_PASS, b, a, b, 4'b0000);
      run_op("sgnj_code2", OP_SGNJ, 3'd2, a, b, BAD_RESULT, 4'b0000);
      run_op("sgnj_code6", OP_SGNJ, 3'd6, a, b, BAD_RESULT, 4'b0000);
      run_op("op_unknown0", 5'd0, RM_RNE, a, b, BAD_RESULT, 4'b0000);
      run_op("op_unknown7", 5'd7, RM_RNE, a, b, BAD_RESULT, 4'b0000);

      repeat (4)
         @(negedge clk);
      $display("Finished %0d operations with %0d value errors and %0d protocol errors",
               op_count, value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // Each operation gets up to 100 cycles
   initial
   begin
      repeat (NUM_OPS * 100)
         @(posedge clk);
      $display("Watchdog expired: not all operations completed within %0d cycles",
               NUM_OPS * 100);
      $display("TEST FAIL");
      $finish;
   end

endmodule

/* source/fpu_top.sv */
// FPU top level with plain ports; connects operand unit, result queue and round-and-pack stage
module fpu_top
#(
   parameter int MUL_BITS    = 4,
   parameter int QUEUE_DEPTH = 2
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        enable,
   input  logic [4:0]  fpu_op,
   input  logic [2:0]  rnd_mode,
   input  logic [63:0] opa,
   input  logic [63:0] opb,
   output logic [63:0] out,
   output logic        ready,
   output logic        overflow,
   output logic        underflow,
   output logic        inexact,
   output logic        invalid
);

   // Pulses when the host has been given its result
   logic done;

   fpu_item_if prod_item ();
   fpu_item_if round_item ();

   fpu_operand_unit #(.MUL_BITS(MUL_BITS)) u_operand_unit
   (
      .clk      (clk),
      .rst      (rst),
      .enable   (enable),
      .fpu_op   (fpu_op),
      .rnd_mode (rnd_mode),
      .opa      (opa),
      .opb      (opb),
      .done     (done),
      .item     (prod_item.source)
   );

   fpu_result_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_result_queue
   (
      .clk      (clk),
      .rst      (rst),
      .in_item  (prod_item.sink),
      .out_item (round_item.source)
   );

   fpu_round_pack u_round_pack
   (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .rnd_mode  (rnd_mode),
      .item      (round_item.sink),
      .done      (done),
      .out       (out),
      .ready     (ready),
      .overflow  (overflow),
      .underflow (underflow),
      .inexact   (inexact),
      .invalid   (invalid)
   );

endmodule

/* source/fpu_round_pack.sv */
// Consumer stage of the FPU that normalizes, rounds and packs each item and drives result and flags
module fpu_round_pack
(
   input  logic        clk,
   input  logic        rst,
   input  logic        enable,
   input  logic [2:0]  rnd_mode,
   fpu_item_if.sink    item,
   output logic        done,
   output logic [63:0] out,
   output logic        ready,
   output logic        overflow,
   output logic        underflow,
   output logic        inexact,
   output logic        invalid
);
   import fp64_pkg::*;
   import fpu_op_pkg::*;

   logic [PROD_W-1:0]  norm_prod;
   logic [MANT_W-1:0]  mant;
   logic [MANT_W:0]    mant_rnd;
   logic               guard, sticky, round_up, trunc_mode;
   logic signed [12:0] exp_norm;
   logic signed [12:0] exp_final;
   fp64_word           res_word;
   logic               ovf, unf, inx, inv;
   logic               accept;

   // Round toward zero truncates; every other code rounds to nearest even
   always_comb
   begin
      case (rnd_mode)
         RM_RNE:  trunc_mode = 1'b0;
         RM_RTZ:  trunc_mode = 1'b1;
         default: trunc_mode = 1'b0;
      endcase
   end

   ////////////////////////////////
   // Normalize and round
   ////////////////////////////////
   always_comb
   begin
      // The product of two normal significands lies in [1, 4)
      norm_prod = item.product[PROD_W-1] ? item.product : item.product << 1;
      exp_norm  = item.product[PROD_W-1] ? $signed(item.exponent) + 13'sd1
                                         : $signed(item.exponent);
      mant      = norm_prod[PROD_W-1 -: MANT_W];
      guard     = norm_prod[PROD_W-1-MANT_W];
      sticky    = |norm_prod[PROD_W-2-MANT_W:0];
      round_up  = ~trunc_mode & guard & (sticky | mant[0]);
      mant_rnd  = {1'b0, mant} + (MANT_W+1)'(round_up);

      // A carry out of rounding leaves 1.0 with the next exponent and a zero fraction
      exp_final = mant_rnd[MANT_W] ? exp_norm + 13'sd1 : exp_norm;

      res_word.fields.sign     = item.sign;
      res_word.fields.exponent = exp_final[EXP_W-1:0];
      res_word.fields.fraction = mant_rnd[FRAC_W-1:0];
      ovf = 1'b0;
      unf = 1'b0;
      inx = guard | sticky;
      inv = 1'b0;

      if (item.bypass || item.special)
      begin
         res_word.bits = item.result;
         inx = 1'b0;
         inv = item.invalid;
      end
      else if (exp_final >= 13'sd2047)
      begin
         ovf = 1'b1;
         inx = 1'b1;
         res_word.fields.exponent = '1;
         res_word.fields.fraction = '0;
         if (trunc_mode)
            res_word.bits = {item.sign, MAX_FINITE_MAG[62:0]};
      end
      else if (exp_final < 13'sd1)
      begin
         // Results below the normal range flush to a signed zero
         unf = 1'b1;
         inx = 1'b1;
         res_word.bits = {item.sign, 63'd0};
      end
   end

   ////////////////////////////////
   // Output handshake
   ////////////////////////////////

   // Take a new item only for a host that is still waiting
   assign accept = item.req & ~item.ack & enable & ~ready;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         item.ack  <= 1'b0;
         done      <= 1'b0;
         ready     <= 1'b0;
         out       <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
         inexact   <= 1'b0;
         invalid   <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (accept)
         begin
            item.ack  <= 1'b1;
            done      <= 1'b1;
            ready     <= 1'b1;
            out       <= res_word.bits;
            overflow  <= ovf;
            underflow <= unf;
            inexact   <= inx;
            invalid   <= inv;
         end
         else if (item.ack && !item.req)
            item.ack <= 1'b0;
         if (!enable)
            ready <= 1'b0;
      end
   end

   // The queue keeps an item offered until this stage has taken it
   assert property (@(posedge clk) disable iff (rst) (item.req && !item.ack) |=> item.req);

endmodule

/* source/fpu_result_queue.sv */
// Result FIFO between the operand unit and the rounding stage, four-phase on both sides
module fpu_result_queue
#(
   parameter int QUEUE_DEPTH = 2
)
(
   input  logic       clk,
   input  logic       rst,
   fpu_item_if.sink   in_item,
   fpu_item_if.source out_item
);
   import fp64_pkg::*;

   localparam int ENTRY_W = 1 + 64 + 1 + 13 + PROD_W + 1 + 1;
   localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);

   logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
   logic [ENTRY_W-1:0] in_entry;
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               draining;
   logic               full, empty, push, pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign in_entry = {in_item.bypass, in_item.result, in_item.sign, in_item.exponent,
                      in_item.product, in_item.special, in_item.invalid};
   assign {out_item.bypass, out_item.result, out_item.sign, out_item.exponent,
           out_item.product, out_item.special, out_item.invalid} = mem[rd_ptr];

   assign full  = (count == CNT_W'(QUEUE_DEPTH));
   assign empty = (count == '0);
   assign push  = in_item.req & ~in_item.ack & ~full;
   // The head is retired only once the sink has dropped ack
   assign pop   = draining & ~out_item.ack;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_entry;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         draining     <= 1'b0;
         in_item.ack  <= 1'b0;
         out_item.req <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr      <= next_ptr(wr_ptr);
            in_item.ack <= 1'b1;
         end
         else if (in_item.ack && !in_item.req)
            in_item.ack <= 1'b0;

         if (!empty && !out_item.req && !out_item.ack && !draining)
            out_item.req <= 1'b1;
         if (out_item.req && out_item.ack)
         begin
            out_item.req <= 1'b0;
            draining     <= 1'b1;
         end
         if (pop)
         begin
            rd_ptr   <= next_ptr(rd_ptr);
            draining <= 1'b0;
         end

         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      (pop |-> !empty) and (count <= CNT_W'(QUEUE_DEPTH)));

endmodule

/* source/fpu_operand_unit.sv */
// Producer stage of the FPU: starts an operation, classifies operands, multiplies and offers the item
module fpu_operand_unit
#(
   parameter int MUL_BITS = 4
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        enable,
   input  logic [4:0]  fpu_op,
   input  logic [2:0]  rnd_mode,
   input  logic [63:0] opa,
   input  logic [63:0] opb,
   input  logic        done,
   fpu_item_if.source  item
);
   import fp64_pkg::*;
   import fpu_op_pkg::*;

   localparam int STEPS    = (MANT_W + MUL_BITS - 1) / MUL_BITS;
   localparam int MPLIER_W = STEPS * MUL_BITS;
   localparam int CNT_W    = $clog2(STEPS + 1);

   fp64_word a_in;
   fp64_word b_in;
   fp64_word sgnj_word;
   fp64_word special_word;

   logic a_zero, a_inf, a_nan;
   logic b_zero, b_inf, b_nan;
   logic mul_op, is_special, mul_invalid, is_mul, start;

   logic                enable_d;
   logic                busy;
   logic                launch;
   logic                mul_run;
   logic [CNT_W-1:0]    step_cnt;
   logic [PROD_W-1:0]   mcand;
   logic [MPLIER_W-1:0] mplier;
   logic [PROD_W-1:0]   partial;

   assign a_in = opa;
   assign b_in = opb;

   ////////////////////////////////
   // Operand classification
   ////////////////////////////////

   // Subnormals have a zero exponent and count as zero
   assign a_zero = (a_in.fields.exponent == '0);
   assign b_zero = (b_in.fields.exponent == '0);
   assign a_inf  = (a_in.fields.exponent == '1) && (a_in.fields.fraction == '0);
   assign b_inf  = (b_in.fields.exponent == '1) && (b_in.fields.fraction == '0);
   assign a_nan  = (a_in.fields.exponent == '1) && (a_in.fields.fraction != '0);
   assign b_nan  = (b_in.fields.exponent == '1) && (b_in.fields.fraction != '0);

   assign mul_op      = (fpu_op == OP_MUL);
   assign is_special  = a_zero | b_zero | a_inf | b_inf | a_nan | b_nan;
   assign mul_invalid = a_nan | b_nan | (a_inf & b_zero) | (a_zero & b_inf);
   assign is_mul      = mul_op & ~is_special;

   // A start is a rising enable seen while idle
   assign start = enable & ~enable_d & ~busy;

   always_comb
   begin
      special_word.bits = '0;
      special_word.fields.sign = a_in.fields.sign ^ b_in.fields.sign;
      if (mul_invalid)
         special_word.bits = QNAN;
      else if (a_inf | b_inf)
         special_word.fields.exponent = '1;
   end

   // Sign injection and the marker word for anything that is not a multiply
   always_comb
   begin
      sgnj_word.bits = BAD_RESULT;
      if (fpu_op == OP_SGNJ)
      begin
         if ((rnd_mode & SGNJ_COPY_MASK) == 3'b000)
         begin
            sgnj_word.bits = opa;
            sgnj_word.fields.sign = b_in.fields.sign;
         end
         else if (rnd_mode == SGNJ_PASS)
            sgnj_word.bits = opa;
      end
   end

   ////////////////////////////////
   // Control and handshake
   ////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         enable_d <= 1'b0;
         busy     <= 1'b0;
         launch   <= 1'b0;
         mul_run  <= 1'b0;
         step_cnt <= '0;
         item.req <= 1'b0;
      end
      else
      begin
         enable_d <= enable;
         launch   <= 1'b0;
         if (start)
         begin
            busy     <= 1'b1;
            launch   <= ~is_mul;
            mul_run  <= is_mul;
            step_cnt <= CNT_W'(STEPS);
         end
         if (launch)
            item.req <= 1'b1;
         if (mul_run)
         begin
            step_cnt <= step_cnt - 1'b1;
            if (step_cnt == CNT_W'(1))
            begin
               mul_run  <= 1'b0;
               item.req <= 1'b1;
            end
         end
         if (item.req && item.ack)
            item.req <= 1'b0;
         // Stay busy until the host has the result
         if (done)
            busy <= 1'b0;
      end
   end

   ////////////////////////////////
   // Item data and multiplier
   ////////////////////////////////

   // MUL_BITS multiplier bits are retired per cycle, least significant first
   assign partial = mcand * PROD_W'(mplier[MUL_BITS-1:0]);

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         item.bypass   <= ~mul_op;
         item.special  <= mul_op & is_special;
         item.invalid  <= mul_op & mul_invalid;
         item.result   <= mul_op ? special_word.bits : sgnj_word.bits;
         item.sign     <= a_in.fields.sign ^ b_in.fields.sign;
         item.exponent <= 13'(a_in.fields.exponent) + 13'(b_in.fields.exponent)
                          - 13'(EXP_BIAS);
         item.product  <= '0;
         mcand         <= PROD_W'({1'b1, a_in.fields.fraction});
         mplier        <= MPLIER_W'({1'b1, b_in.fields.fraction});
      end
      else if (mul_run)
      begin
         item.product <= item.product + partial;
         mcand        <= mcand << MUL_BITS;
         mplier       <= mplier >> MUL_BITS;
      end
   end

   // The offered item holds still until the queue has let go of it
   assert property (@(posedge clk) disable iff (rst)
      item.req |=> $stable({item.bypass, item.result, item.sign, item.exponent,
                            item.product, item.special, item.invalid}));

endmodule

/* source/fpu_item_if.sv */
// Four-phase item channel between FPU stages, used with source and sink modports
interface fpu_item_if;
   import fp64_pkg::*;

   logic              req;
   logic              ack;

   // A finished word that needs no rounding
   logic              bypass;
   logic [63:0]       result;

   // Unrounded multiply data
   logic              sign;
   logic [12:0]       exponent;
   logic [PROD_W-1:0] product;

   // Zero, infinity or NaN already chosen in result
   logic              special;
   logic              invalid;

   modport source
   (
      output req, bypass, result, sign, exponent, product, special, invalid,
      input  ack
   );

   modport sink
   (
      input  req, bypass, result, sign, exponent, product, special, invalid,
      output ack
   );

endinterface

/* source/fpu_op_pkg.sv */
// Operation, rounding and sign-injection codes, imported by the FPU stages and the testbench
package fpu_op_pkg;

   ////////////////////////////////
   // Operation codes on fpu_op
   ////////////////////////////////
   localparam logic [4:0] OP_MUL  = 5'd6;
   localparam logic [4:0] OP_SGNJ = 5'd23;

   ////////////////////////////////
   // Rounding codes on rnd_mode
   ////////////////////////////////
   localparam logic [2:0] RM_RNE = 3'd0;
   localparam logic [2:0] RM_RTZ = 3'd1;

   // For sign injection rnd_mode selects the variant instead of a rounding mode.
   // Codes 0 and 1 copy the sign of opb; they are the codes with no bit set under this mask
   localparam logic [2:0] SGNJ_COPY_MASK = 3'b110;

   // Code 3 returns opa unchanged
   localparam logic [2:0] SGNJ_PASS = 3'd3;

   // Marker word returned for any unsupported operation or variant
   localparam logic [63:0] BAD_RESULT = 64'h0000_0000_DEAD_BEEF;

endpackage

/* source/fp64_pkg.sv */
// Double-precision word layout and constants, imported by the datapath modules and the interface
package fp64_pkg;

   // Field widths of the IEEE 754 binary64 format
   localparam int EXP_W    = 11;
   localparam int FRAC_W   = 52;

   // Significand including the hidden bit, and the exact product of two of them
   localparam int MANT_W   = FRAC_W + 1;
   localparam int PROD_W   = 2 * MANT_W;

   localparam int EXP_BIAS = 1023;

   // Special encodings
   localparam logic [63:0] QNAN           = 64'h7FF8_0000_0000_0000;
   localparam logic [63:0] MAX_FINITE_MAG = 64'h7FEF_FFFF_FFFF_FFFF;

   typedef struct packed
   {
      logic              sign;
      logic [EXP_W-1:0]  exponent;
      logic [FRAC_W-1:0] fraction;
   } fp64_fields;

   // One operand or result word, seen either as raw bits or as its three fields
   typedef union packed
   {
      logic [63:0] bits;
      fp64_fields  fields;
   } fp64_word;

endpackage
